// File: vlog.f
aluPkg.sv
claAdder.sv
barrelShifter.sv
alu.sv
instrDecode.sv
aluRegs.sv
aluCore.sv
aluCore_props.sv
aluTb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 --top-module aluTb -f vlog.f -o aluSim \
    && ./obj_dir/aluSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^>>> PASS$' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: aluTb.sv
// Testbench for the AXI4-Lite ALU peripheral with a reference model of the ALU
`timescale 1ns/1ns

module aluTb;
    import aluPkg::*;

    typedef struct packed {
        aluFlagsT flags;
        wordT     result;
    } expectT;

    // Operation counts per test group with five bus transactions each
    localparam int OP_CHECKS = 8*20 + 10*8 + 4*15 + 10 + 15 + 2;
    localparam int TXN_COUNT = OP_CHECKS*5 + 40;
    localparam int TIMEOUT_CYCLES = TXN_COUNT*4 + 200;

    localparam opcodeT IMM_OPS [10] = '{5'b01000, 5'b01001, 5'b01010, 5'b01011, 5'b10100,
                                        5'b10101, 5'b10110, 5'b10111, 5'b11000, 5'b10010};
    localparam wordT EDGE_A [5] = '{16'h1234, 16'h7FFF, 16'h8000, 16'hFFFF, 16'h8000};
    localparam wordT EDGE_B [5] = '{16'h1234, 16'h8000, 16'h7FFF, 16'h0001, 16'h8000};
    localparam busAddrT MAP_ADDRS [3] = '{ADDR_OPA, ADDR_OPB, ADDR_INSTR};
    localparam busAddrT BAD_ADDRS [4] = '{ADDR_RESULT, ADDR_FLAGS, 5'h14, 5'h1C};

    string regNames [8] = '{"ADD", "SUB", "XOR", "ANDN", "SLL", "SRL", "ROL", "ROR"};
    string immNames [10] = '{"ADDI", "SUBI", "XORI", "ANDNI", "ROLI", "SLLI", "RORI", "SRLI",
                             "LBI", "SLBI"};
    string cmpNames [4] = '{"SEQ", "SLT", "SLE", "SCO"};

    logic   clk = 1'b0;
    logic   arstN;
    axiReqT bus;
    axiRspT rsp;
    int     seed = 32'h5ac9;
    int     cycleCount = 0;
    int     testErrors = 0;
    int     passCount = 0;
    int     failCount = 0;

    aluCore dut (
        .clk  (clk),
        .arstN(arstN),
        .bus  (bus),
        .rsp  (rsp)
    );

    bind aluCore aluCoreProps props (.clk(clk), .arstN(arstN), .bus(bus), .rsp(rsp));

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a bus handshake never completed", cycleCount);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic wordT randWord();
        return wordT'($random(seed));
    endfunction

    function automatic wordT makeInstr(opcodeT op);
        wordT ins;
        ins = randWord();                             // Random immediate and spare fields
        ins[15:11] = op;
        return ins;
    endfunction

    function automatic wordT regInstr(opcodeT op, functT fn);
        wordT ins;
        ins = makeInstr(op);
        ins[1:0] = fn;
        return ins;
    endfunction

    // kind 0 SLL, 1 SRL, 2 ROL, 3 ROR
    function automatic wordT shiftRef(wordT a, logic [3:0] n, int kind);
        logic [31:0] twice;
        twice = {a, a};
        case (kind)
            0:       return a << n;
            1:       return a >> n;
            2:       return wordT'((twice << n) >> OPERAND_WIDTH);
            default: return wordT'(twice >> n);
        endcase
    endfunction

    function automatic expectT refModel(wordT ins, wordT a, wordT b);
        expectT      e;
        logic [4:0]  op;
        logic [1:0]  fn;
        wordT        bb;
        logic [16:0] sum;
        logic [16:0] dif;
        op = ins[15:11];
        fn = ins[1:0];
        bb = b;
        if (op[4:2] == 3'b010) begin
            bb = op[1] ? {11'b0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};  // Logic ops zero extend
        end else if (op[4:2] == 3'b101) begin
            bb = {11'b0, ins[4:0]};
        end
        sum = {1'b0, a} + {1'b0, bb};
        dif = {1'b0, bb} + {1'b0, ~a} + 17'd1;       // B minus A
        e = '0;
        case (op)
            5'b01000, 5'b01001, 5'b01010, 5'b01011, 5'b11011: begin
                case ((op == 5'b11011) ? fn : op[1:0])
                    2'b00:   {e.flags.carry, e.result} = sum;
                    2'b01:   {e.flags.carry, e.result} = dif;
                    2'b10:   e.result = a ^ bb;
                    default: e.result = a & ~bb;
                endcase
            end
            5'b10010: e.result = {a[7:0], ins[7:0]};  // SLBI
            5'b10100: e.result = shiftRef(a, ins[3:0], 2);
            5'b10101: e.result = shiftRef(a, ins[3:0], 0);
            5'b10110: e.result = shiftRef(a, ins[3:0], 3);
            5'b10111: e.result = shiftRef(a, ins[3:0], 1);
            5'b11000: e.result = {{8{ins[7]}}, ins[7:0]};
            5'b11001: e.result = {<<{a}};
            5'b11010: e.result = shiftRef(a, b[3:0], int'(fn));
            5'b11100: e.result = wordT'(a == b);
            5'b11101: e.result = wordT'($signed(a) < $signed(b));
            5'b11110: e.result = wordT'($signed(a) <= $signed(b));
            5'b11111: e.result = wordT'(sum[16]);
            default:  e.flags.illegal = 1'b1;         // Jump, branch, memory, NOP
        endcase
        e.flags.sign = e.result[OPERAND_WIDTH-1];
        e.flags.zero = (e.result == '0);
        return e;
    endfunction

    task automatic writeReg(busAddrT addr, busDataT data, logic [3:0] strb, output respT resp);
        @(posedge clk);
        bus.awvalid <= 1'b1;
        bus.awaddr  <= addr;
        bus.wvalid  <= 1'b1;
        bus.wdata   <= data;
        bus.wstrb   <= strb;
        bus.bready  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!rsp.awready || !rsp.wready);
        bus.awvalid <= 1'b0;
        bus.wvalid  <= 1'b0;
        do begin
            @(posedge clk);
        end while (!rsp.bvalid);
        resp = rsp.bresp;
    endtask

    task automatic readReg(busAddrT addr, output busDataT data, output respT resp);
        @(posedge clk);
        bus.arvalid <= 1'b1;
        bus.araddr  <= addr;
        bus.rready  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!rsp.arready);
        bus.arvalid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!rsp.rvalid);
        data = rsp.rdata;
        resp = rsp.rresp;
    endtask

    task automatic checkValue(string name, busDataT expected, busDataT actual);
        assert (actual === expected)
        else begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkOp(string name, wordT ins, wordT a, wordT b);
        expectT  want;
        busDataT got;
        respT    resp;
        want = refModel(ins, a, b);
        writeReg(ADDR_OPA, busDataT'(a), 4'b0011, resp);
        writeReg(ADDR_OPB, busDataT'(b), 4'b0011, resp);
        writeReg(ADDR_INSTR, busDataT'(ins), 4'b0011, resp);
        readReg(ADDR_RESULT, got, resp);
        checkValue(name, busDataT'(want.result), got);
        readReg(ADDR_FLAGS, got, resp);
        checkValue({name, " flags"}, busDataT'(want.flags), got);
    endtask

    task automatic finishTest(string name);
        if (testErrors == 0) begin
            passCount++;
            $display("Test %s: passed", name);
        end else begin
            failCount++;
            $display("Test %s: failed with %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    initial begin : stimulus
        wordT    a;
        wordT    b;
        wordT    saved [3];
        busDataT got;
        respT    resp;
        bus   <= '0;
        arstN <= 1'b0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;

        for (int i = 0; i < 20; i++) begin
            for (int k = 0; k < 8; k++) begin
                checkOp(regNames[k], regInstr((k < 4) ? 5'b11011 : 5'b11010, functT'(k % 4)),
                        randWord(), randWord());
            end
        end
        finishTest("register-format operations");

        for (int k = 0; k < 10; k++) begin
            for (int i = 0; i < 8; i++) begin
                checkOp(immNames[k], makeInstr(IMM_OPS[k]), randWord(), randWord());
            end
        end
        finishTest("immediate forms");

        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 15; i++) begin
                if (i < 5) begin
                    a = EDGE_A[i];                    // Equal and sign boundary pairs
                    b = EDGE_B[i];
                end else begin
                    a = randWord();
                    b = randWord();
                end
                checkOp(cmpNames[k], makeInstr({3'b111, 2'(k)}), a, b);
            end
        end
        for (int i = 0; i < 10; i++) begin
            checkOp("BTR", makeInstr(5'b11001), randWord(), randWord());
        end
        finishTest("compare and bit reverse");

        for (int op = 0; op < 32; op++) begin
            if (op < 8 || (op >= 12 && op < 18) || op == 19) begin
                checkOp($sformatf("opcode %05b", opcodeT'(op)), makeInstr(opcodeT'(op)),
                        randWord(), randWord());
            end
        end
        checkOp("ADD to zero", regInstr(5'b11011, 2'b00), 16'h1234, 16'hEDCC);
        checkOp("SUB to zero", regInstr(5'b11011, 2'b01), 16'h5555, 16'h5555);
        finishTest("flags and illegal opcodes");

        for (int i = 0; i < 3; i++) begin
            got = $random(seed);                      // Upper half must be dropped
            writeReg(MAP_ADDRS[i], got, 4'hF, resp);
            checkValue("register write response", busDataT'(RESP_OKAY), busDataT'(resp));
            saved[i] = got[15:0];
            readReg(MAP_ADDRS[i], got, resp);
            checkValue("register read-back", busDataT'(saved[i]), got);
            checkValue("register read response", busDataT'(RESP_OKAY), busDataT'(resp));
        end
        writeReg(ADDR_OPA, 32'h0000_5A00, 4'b0010, resp);
        saved[0][15:8] = 8'h5A;
        readReg(ADDR_OPA, got, resp);
        checkValue("high byte strobe", busDataT'(saved[0]), got);
        writeReg(ADDR_OPB, 32'h0000_00C3, 4'b0001, resp);
        saved[1][7:0] = 8'hC3;
        readReg(ADDR_OPB, got, resp);
        checkValue("low byte strobe", busDataT'(saved[1]), got);
        for (int i = 0; i < 4; i++) begin
            writeReg(BAD_ADDRS[i], 32'hFFFF_FFFF, 4'hF, resp);
            checkValue("bad write response", busDataT'(RESP_SLVERR), busDataT'(resp));
        end
        for (int i = 0; i < 3; i++) begin
            readReg(MAP_ADDRS[i], got, resp);
            checkValue("register after bad writes", busDataT'(saved[i]), got);
        end
        readReg(5'h14, got, resp);
        checkValue("unmapped read data", '0, got);
        checkValue("unmapped read response", busDataT'(RESP_SLVERR), busDataT'(resp));
        finishTest("register access");

        // First write sits in its response while a second one waits
        @(posedge clk);
        bus.awvalid <= 1'b1;
        bus.awaddr  <= ADDR_OPA;
        bus.wvalid  <= 1'b1;
        bus.wdata   <= 32'h0000_A55A;
        bus.wstrb   <= 4'b0011;
        bus.bready  <= 1'b0;
        do begin
            @(posedge clk);
        end while (!rsp.awready || !rsp.wready);
        bus.awaddr <= ADDR_OPB;
        bus.wdata  <= 32'h0000_3CC3;
        repeat (5) begin
            @(posedge clk);
            checkValue("write stall BVALID and ready", 32'h4,
                       {29'b0, rsp.bvalid, rsp.awready, rsp.wready});
        end
        bus.bready <= 1'b1;
        do begin
            @(posedge clk);
        end while (!rsp.awready || !rsp.wready);
        bus.awvalid <= 1'b0;
        bus.wvalid  <= 1'b0;
        do begin
            @(posedge clk);
        end while (!rsp.bvalid);
        checkValue("stalled write response", busDataT'(RESP_OKAY), busDataT'(rsp.bresp));

        @(posedge clk);                               // Read held off by RREADY
        bus.arvalid <= 1'b1;
        bus.araddr  <= ADDR_OPA;
        bus.rready  <= 1'b0;
        do begin
            @(posedge clk);
        end while (!rsp.arready);
        bus.arvalid <= 1'b0;
        bus.araddr  <= ADDR_OPB;                      // Held data must not follow the address
        repeat (5) begin
            @(posedge clk);
            checkValue("read stall data", 32'h1_A55A, {15'b0, rsp.rvalid, rsp.rdata[15:0]});
        end
        bus.rready <= 1'b1;
        @(posedge clk);
        readReg(ADDR_OPB, got, resp);
        checkValue("second write after stall", 32'h0000_3CC3, got);
        finishTest("back-pressure");

        $display("Tests passed: %0d, failed: %0d, bound property failure: %0b",
                 passCount, failCount, dut.props.anyFailure);
        if (failCount == 0 && !dut.props.anyFailure) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: aluCore_props.sv
// AXI4-Lite handshake checks bound into the ALU peripheral top level
`timescale 1ns/1ns

module aluCoreProps (
    input logic           clk,
    input logic           arstN,
    input aluPkg::axiReqT bus,
    input aluPkg::axiRspT rsp
);
    import aluPkg::*;

    logic bvalidFail = 1'b0;
    logic awreadyFail = 1'b0;
    logic rdHoldFail = 1'b0;
    logic latencyFail = 1'b0;
    logic resetFail = 1'b0;
    logic anyFailure;                                 // Sampled by the testbench at the end

    assign anyFailure = bvalidFail | awreadyFail | rdHoldFail | latencyFail | resetFail;

    bvalidHeld: assert property (@(posedge clk) disable iff (!arstN)
        rsp.bvalid && !bus.bready |=> rsp.bvalid)
    else begin
        bvalidFail = 1'b1;
        $error("BVALID dropped before BREADY was seen");
    end

    noAcceptInResp: assert property (@(posedge clk) disable iff (!arstN)
        rsp.bvalid |-> !rsp.awready && !rsp.wready)
    else begin
        awreadyFail = 1'b1;
        $error("Write address or data accepted while BVALID was high");
    end

    readHeld: assert property (@(posedge clk) disable iff (!arstN)
        rsp.rvalid && !bus.rready |=> rsp.rvalid && $stable(rsp.rdata) && $stable(rsp.rresp))
    else begin
        rdHoldFail = 1'b1;
        $error("Read data or RVALID changed while RREADY was low");
    end

    wrRespLatency: assert property (@(posedge clk) disable iff (!arstN)
        rsp.awready |=> rsp.bvalid)
    else begin
        latencyFail = 1'b1;
        $error("Write response did not follow one cycle after acceptance");
    end

    rdRespLatency: assert property (@(posedge clk) disable iff (!arstN)
        bus.arvalid && rsp.arready |=> rsp.rvalid)
    else begin
        latencyFail = 1'b1;
        $error("Read data did not follow one cycle after acceptance");
    end

    // First edge out of reset must see both response channels idle
    idleAfterReset: assert property (@(posedge clk)
        $rose(arstN) |-> !rsp.bvalid && !rsp.rvalid)
    else begin
        resetFail = 1'b1;
        $error("BVALID or RVALID high after reset");
    end

endmodule

// File: aluCore.sv
// ALU peripheral top level joining the bus registers, decoder and ALU
`timescale 1ns/1ns

module aluCore (
    input  logic           clk,
    input  logic           arstN,
    input  aluPkg::axiReqT bus,
    output aluPkg::axiRspT rsp
);
    import aluPkg::*;

    wordT   opA;
    wordT   opB;
    wordT   instr;
    opcodeT opcode;
    functT  funct;
    wordT   aIn;
    wordT   bIn;
    logic   legal;
    wordT   result;
    logic   carry;

    aluRegs regs (
        .clk   (clk),
        .arstN (arstN),
        .bus   (bus),
        .rsp   (rsp),
        .result(result),
        .carry (carry),
        .legal (legal),
        .opA   (opA),
        .opB   (opB),
        .instr (instr)
    );

    instrDecode decode (
        .instr (instr),
        .opA   (opA),
        .opB   (opB),
        .opcode(opcode),
        .funct (funct),
        .aIn   (aIn),
        .bIn   (bIn),
        .legal (legal)
    );

    alu datapath (
        .opcode(opcode),
        .funct (funct),
        .aIn   (aIn),
        .bIn   (bIn),
        .result(result),
        .carry (carry)
    );

endmodule

// File: aluRegs.sv
// AXI4-Lite slave with operand and instruction registers, result and flags readback
`timescale 1ns/1ns

module aluRegs (
    input  logic           clk,
    input  logic           arstN,
    input  aluPkg::axiReqT bus,
    output aluPkg::axiRspT rsp,
    input  aluPkg::wordT   result,
    input  logic           carry,
    input  logic           legal,
    output aluPkg::wordT   opA,
    output aluPkg::wordT   opB,
    output aluPkg::wordT   instr
);
    import aluPkg::*;

    wrStateT  wrState;
    logic     wrAccept;
    logic     wrMapped;
    respT     bresp;
    logic     rvalid;
    logic     rdAccept;
    busDataT  rdValue;
    respT     rdResp;
    busDataT  rdata;
    respT     rresp;
    aluFlagsT flags;

    assign flags.illegal = ~legal;
    assign flags.carry   = carry;
    assign flags.sign    = result[OPERAND_WIDTH-1];
    assign flags.zero    = (result == '0);

    // Keep the old byte where its strobe is low, only lanes 0 and 1 are used
    function automatic wordT mergeBytes(wordT old, busDataT data, logic [3:0] strb);
        wordT merged;
        merged = old;
        if (strb[0]) begin
            merged[7:0] = data[7:0];
        end
        if (strb[1]) begin
            merged[15:8] = data[15:8];
        end
        return merged;
    endfunction

    assign wrAccept = (wrState == wrIdle) && bus.awvalid && bus.wvalid;
    assign wrMapped = (bus.awaddr == ADDR_OPA) || (bus.awaddr == ADDR_OPB)
                   || (bus.awaddr == ADDR_INSTR);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrState <= wrIdle;
            opA     <= '0;
            opB     <= '0;
            instr   <= '0;
        end else begin
            case (wrState)
                wrIdle: begin
                    if (wrAccept) begin
                        wrState <= wrResp;
                        case (bus.awaddr)
                            ADDR_OPA:   opA   <= mergeBytes(opA, bus.wdata, bus.wstrb);
                            ADDR_OPB:   opB   <= mergeBytes(opB, bus.wdata, bus.wstrb);
                            ADDR_INSTR: instr <= mergeBytes(instr, bus.wdata, bus.wstrb);
                            default:    ;                     // Read only or unmapped
                        endcase
                    end
                end
                wrResp: begin
                    if (bus.bready) begin
                        wrState <= wrIdle;
                    end
                end
                default: wrState <= wrIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wrAccept) begin
            bresp <= wrMapped ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign rdAccept = bus.arvalid && !rvalid;

    always_comb begin
        rdResp = RESP_OKAY;
        case (bus.araddr)
            ADDR_OPA:    rdValue = busDataT'(opA);
            ADDR_OPB:    rdValue = busDataT'(opB);
            ADDR_INSTR:  rdValue = busDataT'(instr);
            ADDR_RESULT: rdValue = busDataT'(result);
            ADDR_FLAGS:  rdValue = busDataT'(flags);
            default: begin
                rdValue = '0;
                rdResp  = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rvalid <= 1'b0;
        end else if (rdAccept) begin
            rvalid <= 1'b1;
        end else if (bus.rready) begin
            rvalid <= 1'b0;                           // Data taken by host
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rdata <= rdValue;                         // Held until RREADY
            rresp <= rdResp;
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.awready = wrAccept;
        rsp.wready  = wrAccept;
        rsp.bvalid  = (wrState == wrResp);
        rsp.bresp   = bresp;
        rsp.arready = !rvalid;
        rsp.rvalid  = rvalid;
        rsp.rdata   = rdata;
        rsp.rresp   = rresp;
    end

endmodule

// File: instrDecode.sv
// Instruction field split, B operand select from register or immediate, legality check
`timescale 1ns/1ns

module instrDecode (
    input  aluPkg::wordT   instr,
    input  aluPkg::wordT   opA,
    input  aluPkg::wordT   opB,
    output aluPkg::opcodeT opcode,
    output aluPkg::functT  funct,
    output aluPkg::wordT   aIn,
    output aluPkg::wordT   bIn,
    output logic           legal
);
    import aluPkg::*;

    logic [4:0] imm5;
    logic [7:0] imm8;
    wordT       imm5Sext;
    wordT       imm5Zext;
    wordT       imm8Sext;
    wordT       imm8Zext;

    assign opcode = instr[15:11];
    assign funct  = instr[1:0];
    assign imm5   = instr[4:0];
    assign imm8   = instr[7:0];

    assign imm5Sext = {{(OPERAND_WIDTH-5){imm5[4]}}, imm5};
    assign imm5Zext = wordT'(imm5);
    assign imm8Sext = {{(OPERAND_WIDTH-8){imm8[7]}}, imm8};
    assign imm8Zext = wordT'(imm8);

    assign aIn = opA;

    always_comb begin
        bIn = opB;                                    // Register format
        case (opcode)
            5'b01000, 5'b01001: bIn = imm5Sext;       // ADDI, SUBI
            5'b01010, 5'b01011: bIn = imm5Zext;       // XORI, ANDNI
            5'b10100, 5'b10101,
            5'b10110, 5'b10111: bIn = imm5Zext;       // Shift immediates
            5'b10010:           bIn = imm8Zext;       // SLBI
            5'b11000:           bIn = imm8Sext;       // LBI
            default:            bIn = opB;
        endcase
    end

    // Jump, branch, memory and NOP classes are not implemented, SLBI excepted
    always_comb begin
        case (opcode[4:2])
            3'b010, 3'b101, 3'b110, 3'b111: legal = 1'b1;
            3'b100:                         legal = (opcode[1:0] == 2'b10);
            default:                        legal = 1'b0;
        endcase
    end

endmodule

// File: alu.sv
// 16-bit ALU with the operation chosen by opcode class and then low opcode bits or funct
`timescale 1ns/1ns

module alu (
    input  aluPkg::opcodeT opcode,
    input  aluPkg::functT  funct,
    input  aluPkg::wordT   aIn,
    input  aluPkg::wordT   bIn,
    output aluPkg::wordT   result,
    output logic           carry
);
    import aluPkg::*;

    wordT      sum;
    wordT      diff;
    logic      sumCarry;
    logic      diffCarry;
    wordT      shifted;
    shiftKindT shiftKind;
    wordT      reversed;

    claAdder addAB (                                  // A + B
        .inA (aIn),
        .inB (bIn),
        .cIn (1'b0),
        .sum (sum),
        .cOut(sumCarry)
    );

    claAdder subBA (                                  // B + ~A + 1 = B - A
        .inA (bIn),
        .inB (~aIn),
        .cIn (1'b1),
        .sum (diff),
        .cOut(diffCarry)
    );

    // Shift immediates order the kinds differently from funct
    always_comb begin
        shiftKind = funct;
        if (opcode[4:2] == 3'b101) begin
            case (opcode[1:0])
                2'b00:   shiftKind = SHIFT_ROL;
                2'b01:   shiftKind = SHIFT_SLL;
                2'b10:   shiftKind = SHIFT_ROR;
                default: shiftKind = SHIFT_SRL;
            endcase
        end
    end

    barrelShifter shifter (
        .in       (aIn),
        .amount   (bIn[3:0]),
        .shiftKind(shiftKind),
        .out      (shifted)
    );

    always_comb begin
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            reversed[i] = aIn[OPERAND_WIDTH-1-i];
        end
    end

    always_comb begin
        result = '0;                                  // NOP, jump, branch, memory
        carry  = 1'b0;
        case (opcode[4:2])
            3'b010: begin                             // Arithmetic immediate
                case (opcode[1:0])
                    2'b00:   begin result = sum;  carry = sumCarry;  end
                    2'b01:   begin result = diff; carry = diffCarry; end
                    2'b10:   result = aIn ^ bIn;
                    default: result = aIn & ~bIn;
                endcase
            end
            3'b100: begin
                if (opcode[1:0] == 2'b10) begin
                    result = (aIn << 8) | bIn;        // SLBI
                end
            end
            3'b101: result = shifted;                 // Shift immediate
            3'b110: begin
                case (opcode[1:0])
                    2'b00: result = bIn;              // LBI
                    2'b01: result = reversed;         // BTR
                    2'b10: result = shifted;          // Register shift
                    default: begin                    // Register arithmetic
                        case (funct)
                            2'b00:   begin result = sum;  carry = sumCarry;  end
                            2'b01:   begin result = diff; carry = diffCarry; end
                            2'b10:   result = aIn ^ bIn;
                            default: result = aIn & ~bIn;
                        endcase
                    end
                endcase
            end
            3'b111: begin                             // Set on condition
                case (opcode[1:0])
                    2'b00:   result = wordT'(aIn == bIn);
                    2'b01:   result = wordT'($signed(aIn) < $signed(bIn));
                    2'b10:   result = wordT'($signed(aIn) <= $signed(bIn));
                    default: result = wordT'(sumCarry);
                endcase
            end
            default: result = '0;
        endcase
    end

endmodule

// File: barrelShifter.sv
// Logarithmic shifter for logical shifts and rotates by 0 to 15 positions
`timescale 1ns/1ns

module barrelShifter (
    input  aluPkg::wordT      in,
    input  logic [3:0]        amount,
    input  aluPkg::shiftKindT shiftKind,
    output aluPkg::wordT      out
);
    import aluPkg::*;

    wordT s0;
    wordT s1;
    wordT s2;

    // One stage, moves by n when enabled
    function automatic wordT shiftStage(wordT v, logic en, int n, shiftKindT kind);
        wordT r;
        r = v;
        if (en) begin
            case (kind)
                SHIFT_SLL: r = v << n;                                    // Zero fill
                SHIFT_SRL: r = v >> n;
                SHIFT_ROL: r = (v << n) | (v >> (OPERAND_WIDTH - n));   // Wrap top bits
                SHIFT_ROR: r = (v >> n) | (v << (OPERAND_WIDTH - n));   // Wrap low bits
                default:   r = v;
            endcase
        end
        return r;
    endfunction

    assign s0  = shiftStage(in, amount[0], 1, shiftKind);
    assign s1  = shiftStage(s0, amount[1], 2, shiftKind);
    assign s2  = shiftStage(s1, amount[2], 4, shiftKind);
    assign out = shiftStage(s2, amount[3], 8, shiftKind);

endmodule

// File: claAdder.sv
// 16-bit carry-lookahead adder, two lookahead levels over four 4-bit groups
`timescale 1ns/1ns

module claAdder (
    input  aluPkg::wordT inA,
    input  aluPkg::wordT inB,
    input  logic         cIn,
    output aluPkg::wordT sum,
    output logic         cOut
);
    import aluPkg::*;

    wordT       g;                                    // Bit generate
    wordT       p;                                    // Bit propagate
    wordT       c;                                    // Carry into each bit
    logic [3:0] grpG;
    logic [3:0] grpP;
    logic [4:0] grpC;                                 // Carry into each group

    assign g = inA & inB;
    assign p = inA ^ inB;

    for (genvar j = 0; j < 4; j++) begin : genGroup
        assign grpP[j] = &p[4*j+3 -: 4];
        assign grpG[j] = g[4*j+3]
                       | (p[4*j+3] & g[4*j+2])
                       | (p[4*j+3] & p[4*j+2] & g[4*j+1])
                       | (p[4*j+3] & p[4*j+2] & p[4*j+1] & g[4*j]);

        // Carries inside the group come straight from the group carry in
        assign c[4*j]   = grpC[j];
        assign c[4*j+1] = g[4*j] | (p[4*j] & grpC[j]);
        assign c[4*j+2] = g[4*j+1] | (p[4*j+1] & g[4*j])
                        | (p[4*j+1] & p[4*j] & grpC[j]);
        assign c[4*j+3] = g[4*j+2] | (p[4*j+2] & g[4*j+1])
                        | (p[4*j+2] & p[4*j+1] & g[4*j])
                        | (p[4*j+2] & p[4*j+1] & p[4*j] & grpC[j]);
    end

    // Second level lookahead across groups
    assign grpC[0] = cIn;
    assign grpC[1] = grpG[0] | (grpP[0] & cIn);
    assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (grpP[1] & grpP[0] & cIn);
    assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
                   | (grpP[2] & grpP[1] & grpP[0] & cIn);
    assign grpC[4] = grpG[3] | (grpP[3] & grpG[2]) | (grpP[3] & grpP[2] & grpG[1])
                   | (grpP[3] & grpP[2] & grpP[1] & grpG[0])
                   | (grpP[3] & grpP[2] & grpP[1] & grpP[0] & cIn);

    assign sum  = p ^ c;
    assign cOut = grpC[4];

endmodule

// File: aluPkg.sv
// ALU peripheral shared widths, register map, bus structs and state encodings
package aluPkg;

    localparam int OPERAND_WIDTH = 16;                // Fixed by the instruction set
    localparam int BUS_DATA_WIDTH = 32;
    localparam int BUS_ADDR_WIDTH = 5;

    typedef logic [OPERAND_WIDTH-1:0]  wordT;
    typedef logic [4:0]                opcodeT;      // Instr[15:11]
    typedef logic [1:0]                functT;       // Instr[1:0]
    typedef logic [BUS_DATA_WIDTH-1:0] busDataT;
    typedef logic [BUS_ADDR_WIDTH-1:0] busAddrT;
    typedef logic [1:0]                respT;
    typedef logic [1:0]                shiftKindT;

    // Register map, byte addresses
    localparam busAddrT ADDR_OPA    = 5'h00;
    localparam busAddrT ADDR_OPB    = 5'h04;
    localparam busAddrT ADDR_INSTR  = 5'h08;
    localparam busAddrT ADDR_RESULT = 5'h0C;         // Read only
    localparam busAddrT ADDR_FLAGS  = 5'h10;         // Read only

    localparam respT RESP_OKAY   = 2'b00;
    localparam respT RESP_SLVERR = 2'b10;

    // Shifter operations, same order as the register shift funct
    localparam shiftKindT SHIFT_SLL = 2'b00;
    localparam shiftKindT SHIFT_SRL = 2'b01;
    localparam shiftKindT SHIFT_ROL = 2'b10;
    localparam shiftKindT SHIFT_ROR = 2'b11;

    typedef struct packed {
        logic illegal;                                // Bit 3
        logic carry;
        logic sign;
        logic zero;                                   // Bit 0
    } aluFlagsT;

    typedef struct packed {
        logic       awvalid;
        busAddrT    awaddr;
        logic       wvalid;
        busDataT    wdata;
        logic [3:0] wstrb;
        logic       bready;
        logic       arvalid;
        busAddrT    araddr;
        logic       rready;
    } axiReqT;

    typedef struct packed {
        logic    awready;
        logic    wready;
        logic    bvalid;
        respT    bresp;
        logic    arready;
        logic    rvalid;
        busDataT rdata;
        respT    rresp;
    } axiRspT;

    typedef enum logic {
        wrIdle,
        wrResp
    } wrStateT;

endpackage
